/* hdl/display_pkg.sv */
// screen geometry and camera codes for the three-camera overlay, imported by decode and execute
package display_pkg;

  // col and row counters from the VGA timing block
  localparam int SCR_W = 10;

  // one QQVGA window per camera
  localparam int IMG_COLS = 160;
  localparam int IMG_ROWS = 120;
  localparam int IMG_PXLS = IMG_COLS * IMG_ROWS;  // 19200

  // left window starts at column 0
  localparam int COL_CEN_MIN  = 192;  // 0xc0
  localparam int COL_RGHT_MIN = 384;  // 0x180

  // proximity bar sits right after each window
  localparam int BAR_COLS = 8;

  // centroid strip under the windows, 8 segments per window
  localparam int STRIP_ROWS = 8;
  localparam int SEG_COLS   = 20;

  // filter-colour boxes in the marker row
  localparam int BOX_ROW_MIN  = 128;
  localparam int BOX_ROWS     = 8;
  localparam int BOX_COLS     = 8;
  localparam int BOX_LEFT_MIN = 24;  // centre and right boxes start at their windows

  // camera index
  localparam logic [1:0] CAM_LEFT = 2'd0;
  localparam logic [1:0] CAM_CEN  = 2'd1;
  localparam logic [1:0] CAM_RGHT = 2'd2;

endpackage

/* hdl/pixel_pkg.sv */
// pixel, frame-buffer word and address types shared by the execute and result stages
package pixel_pkg;

  import display_pkg::*;

  localparam int CH_W   = 4;   // bits per colour channel
  localparam int BUF_W  = 12;  // frame-buffer word
  localparam int ADDR_W = $clog2(IMG_PXLS);  // 15 bits for 19200 pixels

  typedef logic [CH_W-1:0] chan_t;

  // one buffer word, read as RGB 4:4:4 or as a gray nibble
  typedef union packed {
    struct packed {
      chan_t red;
      chan_t green;
      chan_t blue;
    } rgb;
    struct packed {
      logic [BUF_W-2*CH_W-1:0] spare;  // top nibble, ignored in gray
      chan_t                   gray;   // bits 7:4
      chan_t                   low;
    } mono;
  } frame_word_u;

  typedef logic [ADDR_W-1:0] frame_addr_t;

endpackage

/* hdl/region_decode.sv */
// decode stage that maps col and row to the window, bar, strip and box areas of each camera
`timescale 1ns/1ps

module region_decode import display_pkg::*; (
  input  logic [SCR_W-1:0] col,
  input  logic [SCR_W-1:0] row,
  output logic             img_hit,
  output logic             bar_hit,
  output logic             strip_hit,
  output logic             box_hit,
  output logic             in_img_rows,
  output logic [1:0]       cam,
  output logic [2:0]       seg
);

  logic             win_l, win_c, win_r;
  logic             bar_l, bar_c, bar_r;
  logic             box_l, box_c, box_r;
  logic             strip_rows;
  logic             box_rows;
  logic [SCR_W-1:0] win_off;  // col relative to its window

  // row bands
  assign in_img_rows = row < IMG_ROWS;
  assign strip_rows  = (row >= IMG_ROWS) && (row < IMG_ROWS + STRIP_ROWS);
  assign box_rows    = (row >= BOX_ROW_MIN) && (row < BOX_ROW_MIN + BOX_ROWS);

  // column bands
  assign win_l = col < IMG_COLS;
  assign win_c = (col >= COL_CEN_MIN) && (col < COL_CEN_MIN + IMG_COLS);
  assign win_r = (col >= COL_RGHT_MIN) && (col < COL_RGHT_MIN + IMG_COLS);

  assign bar_l = (col >= IMG_COLS) && (col < IMG_COLS + BAR_COLS);
  assign bar_c = (col >= COL_CEN_MIN + IMG_COLS) &&
                 (col < COL_CEN_MIN + IMG_COLS + BAR_COLS);
  assign bar_r = (col >= COL_RGHT_MIN + IMG_COLS) &&
                 (col < COL_RGHT_MIN + IMG_COLS + BAR_COLS);

  assign box_l = (col >= BOX_LEFT_MIN) && (col < BOX_LEFT_MIN + BOX_COLS);
  assign box_c = (col >= COL_CEN_MIN) && (col < COL_CEN_MIN + BOX_COLS);
  assign box_r = (col >= COL_RGHT_MIN) && (col < COL_RGHT_MIN + BOX_COLS);

  assign img_hit   = in_img_rows && (win_l || win_c || win_r);
  assign bar_hit   = in_img_rows && (bar_l || bar_c || bar_r);
  assign strip_hit = strip_rows && (win_l || win_c || win_r);
  assign box_hit   = box_rows && (box_l || box_c || box_r);

  // boxes have their own column bands and everything else follows the window
  always_comb begin
    if (box_rows) begin
      if (box_c)
        cam = CAM_CEN;
      else if (box_r)
        cam = CAM_RGHT;
      else
        cam = CAM_LEFT;
    end
    else if (win_c || bar_c)
      cam = CAM_CEN;
    else if (win_r || bar_r)
      cam = CAM_RGHT;
    else
      cam = CAM_LEFT;  // also the idle value
  end

  always_comb begin
    if (win_c)
      win_off = SCR_W'(col - COL_CEN_MIN);
    else if (win_r)
      win_off = SCR_W'(col - COL_RGHT_MIN);
    else
      win_off = col;
  end

  assign seg = 3'(win_off / SEG_COLS);  // 0..7 inside a window

endmodule

/* hdl/frame_addr_gen.sv */
// execute stage, one frame-buffer read address per camera stepped by the pixel strobe
`timescale 1ns/1ps

module frame_addr_gen import display_pkg::*, pixel_pkg::*; (
  input  logic        rst,
  input  logic        clk,
  input  logic        new_pxl,
  input  logic        img_hit,
  input  logic        in_img_rows,
  input  logic [1:0]  cam,
  output frame_addr_t frame_addr_l,
  output frame_addr_t frame_addr_c,
  output frame_addr_t frame_addr_r
);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      frame_addr_l <= '0;
      frame_addr_c <= '0;
      frame_addr_r <= '0;
    end
    else if (!in_img_rows) begin
      // below the windows, rewind for the next frame
      frame_addr_l <= '0;
      frame_addr_c <= '0;
      frame_addr_r <= '0;
    end
    else if (img_hit && new_pxl) begin
      case (cam)
        CAM_LEFT: frame_addr_l <= frame_addr_l + 1'b1;
        CAM_CEN:  frame_addr_c <= frame_addr_c + 1'b1;
        CAM_RGHT: frame_addr_r <= frame_addr_r + 1'b1;
        default: ;  // no fourth camera
      endcase
    end
  end

  // a strobe inside a window must still find its counter inside the frame
  addr_in_frame: assert property (@(posedge rst) disable iff (clk)
    (in_img_rows && img_hit && new_pxl) |->
      (((cam == CAM_LEFT) ? frame_addr_l :
        (cam == CAM_CEN)  ? frame_addr_c : frame_addr_r) < frame_addr_t'(IMG_PXLS)))
    else $error("frame_addr_gen: camera %0d address past end of frame", cam);

endmodule

/* hdl/overlay_color.sv */
// execute stage, lights proximity bar, centroid strip and filter box pixels in filter colour
`timescale 1ns/1ps

module overlay_color import display_pkg::*, pixel_pkg::*; (
  input  logic             bar_hit,
  input  logic             strip_hit,
  input  logic             box_hit,
  input  logic [1:0]       cam,
  input  logic [2:0]       seg,
  input  logic [SCR_W-1:0] row,
  input  logic [2:0]       rgbfilter_l,
  input  logic [2:0]       rgbfilter_c,
  input  logic [2:0]       rgbfilter_r,
  input  logic [2:0]       proximity_l,
  input  logic [2:0]       proximity_c,
  input  logic [2:0]       proximity_r,
  input  logic [7:0]       centroid_l,
  input  logic [7:0]       centroid_c,
  input  logic [7:0]       centroid_r,
  output logic             ovl_on,
  output chan_t            ovl_red,
  output chan_t            ovl_green,
  output chan_t            ovl_blue
);

  logic [2:0] filt;
  logic [2:0] prox;
  logic [2:0] prox_inv;
  logic [7:0] cent;
  logic       bar_lit;
  logic       strip_lit;

  // per camera inputs
  always_comb begin
    case (cam)
      CAM_LEFT: begin
        filt = rgbfilter_l;
        prox = proximity_l;
        cent = centroid_l;
      end
      CAM_CEN: begin
        filt = rgbfilter_c;
        prox = proximity_c;
        cent = centroid_c;
      end
      CAM_RGHT: begin
        filt = rgbfilter_r;
        prox = proximity_r;
        cent = centroid_r;
      end
      default: begin
        filt = '0;
        prox = '0;
        cent = '0;
      end
    endcase
  end

  // bar grows up from row 127 in steps of 16 rows
  // proximity 7 lights the whole bar, proximity 0 only rows 112..119
  assign prox_inv = ~prox;
  assign bar_lit  = prox_inv <= row[6:4];

  assign strip_lit = cent[seg];  // one centroid bit per 20-column segment

  assign ovl_on = (bar_hit && bar_lit) || (strip_hit && strip_lit) || box_hit;

  // filter bits are red, green, blue from high to low
  assign ovl_red   = {CH_W{filt[2]}};
  assign ovl_green = {CH_W{filt[1]}};
  assign ovl_blue  = {CH_W{filt[0]}};

endmodule

/* hdl/pixel_select.sv */
// result stage, picks camera image, overlay or black and registers the VGA colour
`timescale 1ns/1ps

module pixel_select import display_pkg::*, pixel_pkg::*; (
  input  logic        rst,
  input  logic        clk,
  input  logic        visible,
  input  logic        img_hit,
  input  logic        rgbmode,
  input  logic        ovl_on,
  input  logic [1:0]  cam,
  input  frame_word_u frame_pixel_l,
  input  frame_word_u frame_pixel_c,
  input  frame_word_u frame_pixel_r,
  input  chan_t       ovl_red,
  input  chan_t       ovl_green,
  input  chan_t       ovl_blue,
  output chan_t       vga_red,
  output chan_t       vga_green,
  output chan_t       vga_blue
);

  frame_word_u word;
  chan_t       nxt_red;
  chan_t       nxt_green;
  chan_t       nxt_blue;

  always_comb begin
    case (cam)
      CAM_LEFT: word = frame_pixel_l;
      CAM_CEN:  word = frame_pixel_c;
      default:  word = frame_pixel_r;
    endcase
  end

  always_comb begin
    nxt_red   = '0;
    nxt_green = '0;
    nxt_blue  = '0;
    if (visible) begin
      if (img_hit) begin
        if (rgbmode) begin
          nxt_red   = word.rgb.red;
          nxt_green = word.rgb.green;
          nxt_blue  = word.rgb.blue;
        end
        else begin
          // gray from the middle nibble
          nxt_red   = word.mono.gray;
          nxt_green = word.mono.gray;
          nxt_blue  = word.mono.gray;
        end
      end
      else if (ovl_on) begin
        nxt_red   = ovl_red;
        nxt_green = ovl_green;
        nxt_blue  = ovl_blue;
      end
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      vga_red   <= '0;
      vga_green <= '0;
      vga_blue  <= '0;
    end
    else begin
      vga_red   <= nxt_red;
      vga_green <= nxt_green;
      vga_blue  <= nxt_blue;
    end
  end

  // blanking reaches the pins one cycle later
  blank_next_cycle: assert property (@(posedge rst) disable iff (clk)
    !visible |=> (vga_red == '0) && (vga_green == '0) && (vga_blue == '0))
    else $error("pixel_select: colour driven during blanking");

endmodule

/* hdl/vga_display.sv */
// top level of the three-camera VGA overlay, connects decode, execute and result stages
`timescale 1ns/1ps

module vga_display import display_pkg::*, pixel_pkg::*; (
  input  logic             rst,  // clock
  input  logic             clk,  // async reset, active high
  input  logic             visible,
  input  logic             new_pxl,
  input  logic [SCR_W-1:0] col,
  input  logic [SCR_W-1:0] row,
  input  logic             rgbmode,
  input  logic [2:0]       rgbfilter_l,
  input  logic [2:0]       proximity_l,
  input  logic [7:0]       centroid_l,
  input  frame_word_u      frame_pixel_l,
  input  logic [2:0]       rgbfilter_c,
  input  logic [2:0]       proximity_c,
  input  logic [7:0]       centroid_c,
  input  frame_word_u      frame_pixel_c,
  input  logic [2:0]       rgbfilter_r,
  input  logic [2:0]       proximity_r,
  input  logic [7:0]       centroid_r,
  input  frame_word_u      frame_pixel_r,
  output frame_addr_t      frame_addr_l,
  output frame_addr_t      frame_addr_c,
  output frame_addr_t      frame_addr_r,
  output chan_t            vga_red,
  output chan_t            vga_green,
  output chan_t            vga_blue
);

  logic       img_hit, bar_hit, strip_hit, box_hit;
  logic       in_img_rows;
  logic [1:0] cam;
  logic [2:0] seg;
  logic       ovl_on;
  chan_t      ovl_red, ovl_green, ovl_blue;

  region_decode u_decode (
    .col, .row,
    .img_hit, .bar_hit, .strip_hit, .box_hit,
    .in_img_rows, .cam, .seg
  );

  frame_addr_gen u_addr (
    .rst, .clk, .new_pxl, .img_hit, .in_img_rows, .cam,
    .frame_addr_l, .frame_addr_c, .frame_addr_r
  );

  overlay_color u_overlay (
    .bar_hit, .strip_hit, .box_hit, .cam, .seg, .row,
    .rgbfilter_l, .rgbfilter_c, .rgbfilter_r,
    .proximity_l, .proximity_c, .proximity_r,
    .centroid_l, .centroid_c, .centroid_r,
    .ovl_on, .ovl_red, .ovl_green, .ovl_blue
  );

  pixel_select u_select (
    .rst, .clk, .visible, .img_hit, .rgbmode, .ovl_on, .cam,
    .frame_pixel_l, .frame_pixel_c, .frame_pixel_r,
    .ovl_red, .ovl_green, .ovl_blue,
    .vga_red, .vga_green, .vga_blue
  );

endmodule

/* verification/tb_checks.svh */
// typed compare tasks and check counters, included inside the testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

// one colour channel against its expected value
task automatic check_color(input string name, input chan_t expected, input chan_t actual);
  if (actual !== expected) begin
    fail_count++;
    $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
  end
  else begin
    pass_count++;
  end
endtask

// one frame-buffer address against its expected value
task automatic check_addr(input string name, input frame_addr_t expected,
                          input frame_addr_t actual);
  if (actual !== expected) begin
    fail_count++;
    $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
  end
  else begin
    pass_count++;
  end
endtask

// one line per finished test
task automatic report_test(input string name, input int fails_before);
  if (fail_count == fails_before)
    $display("%s test: all checks passed", name);
  else
    $display("%s test: %0d checks failed", name, fail_count - fails_before);
endtask

`endif

/* verification/tb_vga_display.sv */
// directed testbench for vga_display that drives col/row through a frame-buffer model and checks colours
`timescale 1ns/1ps

module tb_vga_display import display_pkg::*, pixel_pkg::*; ();

  localparam int N_STEP = 6;  // pixels stepped per window
  localparam int TEST_CYCLES = 6 + 2 * (3 * N_STEP + 2) + 2 * (3 + 6 * (N_STEP + 1)) +
                               (1 + 6 * (IMG_ROWS / 8 + 8)) + (1 + 2 * (3 + 6));
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic             rst;  // clock
  logic             clk;  // reset
  logic             visible;
  logic             new_pxl;
  logic [SCR_W-1:0] col;
  logic [SCR_W-1:0] row;
  logic             rgbmode;
  logic [2:0]       rgbfilter_l, rgbfilter_c, rgbfilter_r;
  logic [2:0]       proximity_l, proximity_c, proximity_r;
  logic [7:0]       centroid_l, centroid_c, centroid_r;
  frame_word_u      frame_pixel_l, frame_pixel_c, frame_pixel_r;
  frame_addr_t      frame_addr_l, frame_addr_c, frame_addr_r;
  chan_t            vga_red, vga_green, vga_blue;

  integer      seed = 32'hf567b014;
  int          cycle_count = 0;
  frame_addr_t exp_addr [3];
  logic [2:0]  filt_v [3];
  logic [2:0]  prox_v [3];
  logic [7:0]  cent_v [3];
  int          win_base [3] = '{0, COL_CEN_MIN, COL_RGHT_MIN};
  int          box_base [3] = '{BOX_LEFT_MIN, COL_CEN_MIN, COL_RGHT_MIN};

  `include "tb_checks.svh"

  vga_display uut (.*);

  // frame-buffer model scrambles the address with a per-camera key
  function automatic frame_word_u model_word(input int cam_i, input frame_addr_t a);
    logic [BUF_W-1:0] key;
    logic [BUF_W-1:0] mixed;
    case (cam_i)
      0:       key = 12'ha5c;
      1:       key = 12'h3c9;
      default: key = 12'h1e7;
    endcase
    mixed = BUF_W'(a * 273) ^ BUF_W'(a >> BUF_W) ^ key;
    return frame_word_u'(mixed);
  endfunction

  assign frame_pixel_l = model_word(0, frame_addr_l);  // combinational read
  assign frame_pixel_c = model_word(1, frame_addr_c);
  assign frame_pixel_r = model_word(2, frame_addr_r);

  initial begin
    rst = 1'b0;
    forever #50 rst = ~rst;
  end

  always @(posedge rst) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  // drive one pixel, let it register, sample mid-cycle
  task automatic apply(input logic [SCR_W-1:0] c, input logic [SCR_W-1:0] r,
                       input logic vis, input logic np);
    @(posedge rst);
    col     <= c;
    row     <= r;
    visible <= vis;
    new_pxl <= np;
    @(posedge rst);
    new_pxl <= 1'b0;  // one strobe only
    @(negedge rst);
  endtask

  task automatic check_vga(input chan_t r, input chan_t g, input chan_t b);
    check_color("vga_red", r, vga_red);
    check_color("vga_green", g, vga_green);
    check_color("vga_blue", b, vga_blue);
  endtask

  task automatic check_addresses();
    check_addr("frame_addr_l", exp_addr[0], frame_addr_l);
    check_addr("frame_addr_c", exp_addr[1], frame_addr_c);
    check_addr("frame_addr_r", exp_addr[2], frame_addr_r);
  endtask

  // lit pixels show each filter bit across its channel
  task automatic check_overlay(input int i, input logic lit);
    if (lit)
      check_vga({CH_W{filt_v[i][2]}}, {CH_W{filt_v[i][1]}}, {CH_W{filt_v[i][0]}});
    else
      check_vga('0, '0, '0);
  endtask

  task automatic load_camera_inputs();
    for (int i = 0; i < 3; i++) begin
      filt_v[i] = 3'($random(seed));
      if (filt_v[i] == 3'b000)
        filt_v[i] = 3'b111;  // black filter would hide the overlay
      prox_v[i] = 3'($random(seed));
      cent_v[i] = 8'($random(seed));
    end
    @(posedge rst);
    rgbfilter_l <= filt_v[0];
    rgbfilter_c <= filt_v[1];
    rgbfilter_r <= filt_v[2];
    proximity_l <= prox_v[0];
    proximity_c <= prox_v[1];
    proximity_r <= prox_v[2];
    centroid_l  <= cent_v[0];
    centroid_c  <= cent_v[1];
    centroid_r  <= cent_v[2];
  endtask

  task automatic test_reset();
    int fails_before;
    fails_before = fail_count;
    for (int i = 0; i < 3; i++)
      exp_addr[i] = '0;
    @(posedge rst);
    clk     <= 1'b1;
    visible <= 1'b1;  // reset must win over busy inputs
    new_pxl <= 1'b1;
    col     <= SCR_W'(10);
    row     <= SCR_W'(10);
    rgbmode <= 1'b1;
    repeat (3) begin
      @(negedge rst);
      check_addresses();
      check_vga('0, '0, '0);
      @(posedge rst);
    end
    clk     <= 1'b0;
    visible <= 1'b0;
    new_pxl <= 1'b0;
    @(posedge rst);
    @(negedge rst);
    check_addresses();
    check_vga('0, '0, '0);
    report_test("reset", fails_before);
  endtask

  task automatic test_addr_count();
    int fails_before;
    fails_before = fail_count;
    for (int i = 0; i < 3; i++) begin
      for (int n = 0; n < N_STEP; n++) begin
        apply(SCR_W'(win_base[i] + n), SCR_W'(5), 1'b1, 1'b1);
        exp_addr[i]++;
        check_addresses();
      end
    end
    apply(SCR_W'(IMG_COLS + BAR_COLS + 4), SCR_W'(5), 1'b1, 1'b1);  // gap before centre
    check_addresses();
    apply(SCR_W'(0), SCR_W'(IMG_ROWS), 1'b1, 1'b0);
    for (int i = 0; i < 3; i++)
      exp_addr[i] = '0;
    check_addresses();
    report_test("address", fails_before);
  endtask

  task automatic test_image(input logic mode, input string name);
    int               fails_before;
    logic [BUF_W-1:0] raw;
    chan_t            gray;
    fails_before = fail_count;
    apply(SCR_W'(IMG_COLS + BAR_COLS + 4), SCR_W'(IMG_ROWS), 1'b1, 1'b0);  // rewind
    for (int i = 0; i < 3; i++)
      exp_addr[i] = '0;
    check_addresses();
    @(posedge rst);
    rgbmode <= mode;
    for (int i = 0; i < 3; i++) begin
      for (int k = 0; k < N_STEP; k++) begin
        raw = model_word(i, exp_addr[i]);  // word under the current address
        apply(SCR_W'(win_base[i] + k), SCR_W'(7), 1'b1, 1'b1);
        gray = raw[7:4];
        if (mode)
          check_vga(raw[11:8], raw[7:4], raw[3:0]);
        else
          check_vga(gray, gray, gray);
        exp_addr[i]++;
        check_addresses();
      end
      apply(SCR_W'(win_base[i] + 2), SCR_W'(7), 1'b0, 1'b0);
      check_vga('0, '0, '0);  // blanked
    end
    report_test(name, fails_before);
  endtask

  task automatic test_bars_strip();
    int               fails_before;
    logic [SCR_W-1:0] r;
    fails_before = fail_count;
    load_camera_inputs();
    for (int i = 0; i < 3; i++) begin
      for (int y = 0; y < IMG_ROWS; y += 8) begin
        r = SCR_W'(y);
        apply(SCR_W'(win_base[i] + IMG_COLS + (y / 8) % BAR_COLS), r, 1'b1, 1'b0);
        // lit from row 16 * (7 - proximity) down to the last window row
        check_overlay(i, y >= 16 * (7 - int'(prox_v[i])));
      end
      for (int s = 0; s < 8; s++) begin
        apply(SCR_W'(win_base[i] + s * SEG_COLS + 7), SCR_W'(IMG_ROWS + 3), 1'b1, 1'b0);
        check_overlay(i, cent_v[i][s]);
      end
    end
    report_test("bar and strip", fails_before);
  endtask

  task automatic test_boxes();
    int fails_before;
    int blank_col [6];
    int blank_row [6];
    fails_before = fail_count;
    blank_col = '{100, 34, 200, 175, 600, 300};
    blank_row = '{131, 129, 133, 60, 50, 140};  // box row gaps, bar gaps, below boxes
    load_camera_inputs();
    for (int i = 0; i < 3; i++) begin
      apply(SCR_W'(box_base[i] + 4), SCR_W'(BOX_ROW_MIN + 3), 1'b1, 1'b0);
      check_overlay(i, 1'b1);
    end
    for (int j = 0; j < 6; j++) begin
      apply(SCR_W'(blank_col[j]), SCR_W'(blank_row[j]), 1'b1, 1'b0);
      check_vga('0, '0, '0);
    end
    report_test("filter box", fails_before);
  endtask

  initial begin
    clk         = 1'b0;
    visible     = 1'b0;
    new_pxl     = 1'b0;
    col         = '0;
    row         = '0;
    rgbmode     = 1'b0;
    rgbfilter_l = '0;
    rgbfilter_c = '0;
    rgbfilter_r = '0;
    proximity_l = '0;
    proximity_c = '0;
    proximity_r = '0;
    centroid_l  = '0;
    centroid_c  = '0;
    centroid_r  = '0;
    test_reset();
    test_addr_count();
    test_image(1'b1, "rgb image");
    test_image(1'b0, "gray image");
    test_bars_strip();
    test_boxes();
    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verification
hdl/display_pkg.sv
hdl/pixel_pkg.sv
hdl/region_decode.sv
hdl/frame_addr_gen.sv
hdl/overlay_color.sv
hdl/pixel_select.sv
hdl/vga_display.sv
verification/tb_vga_display.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the vga_display testbench with Verilator.
# The result is decided by searching the log for the fail message.

ROOT=$(cd "$(dirname "$0")" && pwd)
BUILD=obj_dir
LOG=sim.log

cd "$ROOT" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_vga_display \
  -Mdir "$BUILD" \
  -o Vtb_vga_display
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

"./$BUILD/Vtb_vga_display" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

echo "simulation passed, log in $LOG"
exit 0
